// ==== rv_pkg.sv ====
package rv_pkg;

    localparam int xlen = 32;
    localparam int dmem_words = 64;

    typedef logic [xlen-1:0] word_t;          // data, address or instruction
    typedef logic [4:0] reg_addr_t;
    typedef logic [6:0] opcode_t;
    typedef logic [3:0] alu_ctrl_t;
    typedef logic [2:0] imm_sel_t;
    typedef logic [1:0] result_sel_t;
    typedef logic [1:0] pc_sel_t;
    typedef logic [1:0] alu_op_t;             // decoder internal op class
    typedef logic [$clog2(dmem_words)-1:0] dmem_addr_t;

    // major opcodes of the supported subset
    localparam opcode_t op_load   = 7'b0000011;
    localparam opcode_t op_store  = 7'b0100011;
    localparam opcode_t op_reg    = 7'b0110011;
    localparam opcode_t op_branch = 7'b1100011;
    localparam opcode_t op_imm    = 7'b0010011;
    localparam opcode_t op_jal    = 7'b1101111;
    localparam opcode_t op_jalr   = 7'b1100111;
    localparam opcode_t op_lui    = 7'b0110111;

    localparam alu_ctrl_t alu_add  = 4'd0;
    localparam alu_ctrl_t alu_sub  = 4'd1;
    localparam alu_ctrl_t alu_and  = 4'd2;
    localparam alu_ctrl_t alu_or   = 4'd3;
    localparam alu_ctrl_t alu_slt  = 4'd4;
    localparam alu_ctrl_t alu_xor  = 4'd5;
    localparam alu_ctrl_t alu_sltu = 4'd6;
    localparam alu_ctrl_t alu_sll  = 4'd7;
    localparam alu_ctrl_t alu_srl  = 4'd8;
    localparam alu_ctrl_t alu_sra  = 4'd9;

    localparam alu_op_t aluop_add    = 2'd0;
    localparam alu_op_t aluop_sub    = 2'd1;
    localparam alu_op_t aluop_func   = 2'd2;  // decode funct3/funct7
    localparam alu_op_t aluop_branch = 2'd3;

    localparam imm_sel_t imm_i = 3'd0;
    localparam imm_sel_t imm_s = 3'd1;
    localparam imm_sel_t imm_b = 3'd2;
    localparam imm_sel_t imm_j = 3'd3;
    localparam imm_sel_t imm_u = 3'd4;

    localparam result_sel_t res_alu = 2'd0;
    localparam result_sel_t res_mem = 2'd1;
    localparam result_sel_t res_pc4 = 2'd2;
    localparam result_sel_t res_imm = 2'd3;

    localparam pc_sel_t pc_plus4  = 2'd0;
    localparam pc_sel_t pc_branch = 2'd1;     // pc + imm
    localparam pc_sel_t pc_jalr   = 2'd2;     // rs1 + imm, bit 0 cleared

endpackage

// ==== rv_controller.sv ====
`timescale 1ns/1ps

module rv_controller (
    input  rv_pkg::opcode_t     opcode,
    input  logic [2:0]          funct3,
    input  logic [6:0]          funct7,
    input  logic                alu_zero,
    output logic                alu_src,
    output logic                memwrite,
    output logic                regwrite,
    output rv_pkg::alu_ctrl_t   alu_control,
    output rv_pkg::pc_sel_t     pc_src,
    output rv_pkg::imm_sel_t    imm_sel,
    output rv_pkg::result_sel_t result_src
);

    rv_pkg::alu_op_t alu_op;
    logic            is_reg;
    logic            alt_funct;   // funct7 marks sub / sra

    assign is_reg    = (opcode == rv_pkg::op_reg);
    assign alt_funct = (funct7 == 7'b0100000);

    always_comb begin
        alu_src    = 1'b0;
        memwrite   = 1'b0;
        regwrite   = 1'b0;
        imm_sel    = rv_pkg::imm_i;
        result_src = rv_pkg::res_alu;
        pc_src     = rv_pkg::pc_plus4;
        alu_op     = rv_pkg::aluop_add;
        case (opcode)
            rv_pkg::op_load: begin
                regwrite   = 1'b1;
                alu_src    = 1'b1;                 // address = rs1 + imm
                result_src = rv_pkg::res_mem;
            end
            rv_pkg::op_store: begin
                imm_sel  = rv_pkg::imm_s;
                alu_src  = 1'b1;
                memwrite = 1'b1;
            end
            rv_pkg::op_reg: begin
                regwrite = 1'b1;
                alu_op   = rv_pkg::aluop_func;
            end
            rv_pkg::op_imm: begin
                regwrite = 1'b1;
                alu_src  = 1'b1;
                alu_op   = rv_pkg::aluop_func;
            end
            rv_pkg::op_branch: begin
                imm_sel = rv_pkg::imm_b;
                alu_op  = rv_pkg::aluop_branch;
                // zero flag meaning depends on the compare used
                case (funct3)
                    3'b000:         pc_src = alu_zero ? rv_pkg::pc_branch : rv_pkg::pc_plus4;
                    3'b001:         pc_src = alu_zero ? rv_pkg::pc_plus4 : rv_pkg::pc_branch;
                    3'b100, 3'b110: pc_src = alu_zero ? rv_pkg::pc_plus4 : rv_pkg::pc_branch;
                    3'b101, 3'b111: pc_src = alu_zero ? rv_pkg::pc_branch : rv_pkg::pc_plus4;
                    default:        pc_src = rv_pkg::pc_plus4;
                endcase
            end
            rv_pkg::op_jal: begin
                regwrite   = 1'b1;
                imm_sel    = rv_pkg::imm_j;
                result_src = rv_pkg::res_pc4;
                pc_src     = rv_pkg::pc_branch;
            end
            rv_pkg::op_jalr: begin
                regwrite   = 1'b1;
                result_src = rv_pkg::res_pc4;
                pc_src     = rv_pkg::pc_jalr;
            end
            rv_pkg::op_lui: begin
                regwrite   = 1'b1;
                imm_sel    = rv_pkg::imm_u;
                result_src = rv_pkg::res_imm;
            end
            default: ;                             // unknown, no writes
        endcase
    end

    always_comb begin
        alu_control = rv_pkg::alu_add;
        case (alu_op)
            rv_pkg::aluop_add: alu_control = rv_pkg::alu_add;
            rv_pkg::aluop_sub: alu_control = rv_pkg::alu_sub;
            rv_pkg::aluop_func: begin
                case (funct3)
                    3'b000: alu_control = (is_reg && alt_funct) ? rv_pkg::alu_sub
                                                                : rv_pkg::alu_add;
                    3'b001: alu_control = rv_pkg::alu_sll;
                    3'b010: alu_control = rv_pkg::alu_slt;
                    3'b011: alu_control = rv_pkg::alu_sltu;
                    3'b100: alu_control = rv_pkg::alu_xor;
                    3'b101: alu_control = alt_funct ? rv_pkg::alu_sra : rv_pkg::alu_srl;
                    3'b110: alu_control = rv_pkg::alu_or;
                    default: alu_control = rv_pkg::alu_and;
                endcase
            end
            default: begin
                case (funct3)
                    3'b100, 3'b101: alu_control = rv_pkg::alu_slt;   // blt / bge
                    3'b110, 3'b111: alu_control = rv_pkg::alu_sltu;  // bltu / bgeu
                    default:        alu_control = rv_pkg::alu_xor;   // beq / bne
                endcase
            end
        endcase
    end

endmodule

// ==== rv_imm_gen.sv ====
`timescale 1ns/1ps

module rv_imm_gen (
    input  rv_pkg::word_t    instr,
    input  rv_pkg::imm_sel_t imm_sel,
    output rv_pkg::word_t    imm
);

    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_sel)
            rv_pkg::imm_i: imm = {{20{sign}}, instr[31:20]};
            rv_pkg::imm_s: imm = {{20{sign}}, instr[31:25], instr[11:7]};
            rv_pkg::imm_b: imm = {{19{sign}}, sign, instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
            rv_pkg::imm_j: imm = {{11{sign}}, sign, instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
            rv_pkg::imm_u: imm = {instr[31:12], 12'b0};     // low bits zero
            default:       imm = '0;
        endcase
    end

endmodule

// ==== rv_regfile.sv ====
`timescale 1ns/1ps

module rv_regfile (
    input  logic              clk,
    input  logic              reset,
    input  rv_pkg::reg_addr_t rs1,
    input  rv_pkg::reg_addr_t rs2,
    input  rv_pkg::reg_addr_t rd,
    input  logic              we,
    input  rv_pkg::word_t     wdata,
    output rv_pkg::word_t     rdata1,
    output rv_pkg::word_t     rdata2
);

    rv_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (rd != 5'd0)) begin   // x0 stays zero
            regs[rd] <= wdata;
        end
    end

    // asynchronous reads
    assign rdata1 = regs[rs1];
    assign rdata2 = regs[rs2];

endmodule

// ==== rv_alu.sv ====
`timescale 1ns/1ps

module rv_alu (
    input  rv_pkg::word_t     a,
    input  rv_pkg::word_t     b,
    input  rv_pkg::alu_ctrl_t alu_control,
    output rv_pkg::word_t     result,
    output logic              zero
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = ($signed(a) < $signed(b));
    assign lt_unsigned = (a < b);

    always_comb begin
        case (alu_control)
            rv_pkg::alu_add:  result = a + b;
            rv_pkg::alu_sub:  result = a - b;
            rv_pkg::alu_and:  result = a & b;
            rv_pkg::alu_or:   result = a | b;
            rv_pkg::alu_xor:  result = a ^ b;
            rv_pkg::alu_slt:  result = {31'b0, lt_signed};
            rv_pkg::alu_sltu: result = {31'b0, lt_unsigned};
            rv_pkg::alu_sll:  result = a << shamt;
            rv_pkg::alu_srl:  result = a >> shamt;
            rv_pkg::alu_sra:  result = $unsigned($signed(a) >>> shamt);  // sign fill
            default:          result = '0;
        endcase
    end

    assign zero = (result == '0);

endmodule

// ==== rv_data_mem.sv ====
`timescale 1ns/1ps

module rv_data_mem (
    input  logic               clk,
    input  logic               reset,
    input  rv_pkg::dmem_addr_t addr,
    input  logic               we,
    input  rv_pkg::word_t      wdata,
    output rv_pkg::word_t      rdata
);

    rv_pkg::word_t mem [rv_pkg::dmem_words];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < rv_pkg::dmem_words; i++) begin
                mem[i] <= '0;
            end
        end else if (we) begin
            mem[addr] <= wdata;                  // whole word only
        end
    end

    assign rdata = mem[addr];                    // async read

endmodule

// ==== rv_result_select.sv ====
`timescale 1ns/1ps

module rv_result_select (
    input  rv_pkg::result_sel_t result_src,
    input  rv_pkg::pc_sel_t     pc_src,
    input  rv_pkg::word_t       pc,
    input  rv_pkg::word_t       imm,
    input  rv_pkg::word_t       alu_result,
    input  rv_pkg::word_t       mem_rdata,
    input  rv_pkg::word_t       rs1_data,
    output rv_pkg::word_t       wdata,
    output rv_pkg::word_t       next_pc
);

    rv_pkg::word_t pc_plus4;
    rv_pkg::word_t jalr_target;

    assign pc_plus4    = pc + 32'd4;
    assign jalr_target = (rs1_data + imm) & ~32'd1;   // lsb forced low

    always_comb begin
        case (result_src)
            rv_pkg::res_alu: wdata = alu_result;
            rv_pkg::res_mem: wdata = mem_rdata;
            rv_pkg::res_pc4: wdata = pc_plus4;    // link address
            default:         wdata = imm;
        endcase
    end

    always_comb begin
        case (pc_src)
            rv_pkg::pc_branch: next_pc = pc + imm;
            rv_pkg::pc_jalr:   next_pc = jalr_target;
            default:           next_pc = pc_plus4;
        endcase
    end

endmodule

// ==== rv_core.sv ====
`timescale 1ns/1ps

module rv_core (
    input  logic              clk,
    input  logic              reset,
    input  logic              instr_valid,
    input  rv_pkg::word_t     instr,
    output logic              instr_ready,
    output logic              res_valid,
    output rv_pkg::word_t     res_pc,
    output rv_pkg::reg_addr_t res_rd,
    output logic              res_we,
    output rv_pkg::word_t     res_data,
    output rv_pkg::word_t     res_next_pc,
    input  logic              res_ready
);

    rv_pkg::word_t       pc_q;
    logic                accept;

    rv_pkg::opcode_t     opcode;
    rv_pkg::reg_addr_t   rd;
    rv_pkg::reg_addr_t   rs1;
    rv_pkg::reg_addr_t   rs2;
    logic [2:0]          funct3;
    logic [6:0]          funct7;

    logic                alu_src;
    logic                memwrite;
    logic                regwrite;
    rv_pkg::alu_ctrl_t   alu_control;
    rv_pkg::pc_sel_t     pc_src;
    rv_pkg::imm_sel_t    imm_sel;
    rv_pkg::result_sel_t result_src;

    rv_pkg::word_t       imm;
    rv_pkg::word_t       rs1_data;
    rv_pkg::word_t       rs2_data;
    rv_pkg::word_t       alu_b;
    rv_pkg::word_t       alu_result;
    logic                alu_zero;
    rv_pkg::word_t       mem_rdata;
    rv_pkg::word_t       wdata;
    rv_pkg::word_t       next_pc;

    assign opcode = instr[6:0];
    assign rd     = instr[11:7];
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];
    assign funct7 = instr[31:25];

    // free slot, or the waiting record leaves this cycle
    assign instr_ready = !res_valid || res_ready;
    assign accept      = instr_valid && instr_ready;

    rv_controller u_ctrl (
        .opcode(opcode), .funct3(funct3), .funct7(funct7), .alu_zero(alu_zero),
        .alu_src(alu_src), .memwrite(memwrite), .regwrite(regwrite),
        .alu_control(alu_control), .pc_src(pc_src), .imm_sel(imm_sel),
        .result_src(result_src)
    );

    rv_imm_gen u_imm (.instr(instr), .imm_sel(imm_sel), .imm(imm));

    rv_regfile u_rf (
        .clk(clk), .reset(reset), .rs1(rs1), .rs2(rs2), .rd(rd),
        .we(regwrite && accept), .wdata(wdata), .rdata1(rs1_data), .rdata2(rs2_data)
    );

    assign alu_b = alu_src ? imm : rs2_data;

    rv_alu u_alu (
        .a(rs1_data), .b(alu_b), .alu_control(alu_control),
        .result(alu_result), .zero(alu_zero)
    );

    rv_data_mem u_dmem (
        .clk(clk), .reset(reset), .addr(alu_result[7:2]),   // word index
        .we(memwrite && accept), .wdata(rs2_data), .rdata(mem_rdata)
    );

    rv_result_select u_sel (
        .result_src(result_src), .pc_src(pc_src), .pc(pc_q), .imm(imm),
        .alu_result(alu_result), .mem_rdata(mem_rdata), .rs1_data(rs1_data),
        .wdata(wdata), .next_pc(next_pc)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pc_q      <= '0;
            res_valid <= 1'b0;
        end else if (accept) begin
            pc_q      <= next_pc;
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;                   // record consumed
        end
    end

    // record payload, held while stalled
    always_ff @(posedge clk) begin
        if (accept) begin
            res_pc      <= pc_q;
            res_rd      <= rd;
            res_we      <= regwrite;
            res_data    <= wdata;
            res_next_pc <= next_pc;
        end
    end

endmodule

// ==== tb_rv_core.sv ====
`timescale 1ns/1ps

module tb_rv_core;

    typedef struct packed {
        rv_pkg::word_t     pc;
        rv_pkg::reg_addr_t rd;
        logic              we;
        rv_pkg::word_t     data;
        rv_pkg::word_t     next_pc;
    } rec_t;

    localparam int wait_limit = 200;

    logic clk = 1'b0;
    logic reset, instr_valid, instr_ready, res_valid, res_we, res_ready;
    rv_pkg::word_t instr, res_pc, res_data, res_next_pc;
    rv_pkg::reg_addr_t res_rd;

    rv_pkg::word_t m_regs [32];              // model state
    rv_pkg::word_t m_mem [64];
    rv_pkg::word_t m_pc;
    rv_pkg::word_t prog [$];
    rec_t exp_q [$];
    logic held;                              // record register expected full
    integer seed = 32'h620c_4a55;
    integer ready_seed;
    int errors = 0;
    int timeouts = 0;

    rv_core dut0 (
        .clk(clk), .reset(reset), .instr_valid(instr_valid), .instr(instr),
        .instr_ready(instr_ready), .res_valid(res_valid), .res_pc(res_pc), .res_rd(res_rd),
        .res_we(res_we), .res_data(res_data), .res_next_pc(res_next_pc), .res_ready(res_ready)
    );

    always #5 clk = ~clk;

    function automatic rv_pkg::word_t enc_r(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3,
                                            int rd);
        return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), rv_pkg::op_reg};
    endfunction

    function automatic rv_pkg::word_t enc_i(logic [11:0] imm, int rs1, logic [2:0] f3, int rd,
                                            rv_pkg::opcode_t op);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    function automatic rv_pkg::word_t enc_s(logic [11:0] imm, int rs2, int rs1);
        return {imm[11:5], 5'(rs2), 5'(rs1), 3'b010, imm[4:0], rv_pkg::op_store};
    endfunction

    function automatic rv_pkg::word_t enc_b(logic [12:0] off, int rs1, int rs2, logic [2:0] f3);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], rv_pkg::op_branch};
    endfunction

    function automatic rv_pkg::word_t enc_j(logic [20:0] off, int rd);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), rv_pkg::op_jal};
    endfunction

    function automatic rv_pkg::word_t random_alu();
        logic [31:0] r;
        logic [6:0]  f7;
        r  = $random(seed);
        f7 = (r[18] && (r[2:0] == 3'd0 || r[2:0] == 3'd5)) ? 7'b0100000 : 7'b0;
        if (r[19])
            return enc_r(f7, r[17:13], r[12:8], r[2:0], r[7:3]);
        if (r[2:0] == 3'd1 || r[2:0] == 3'd5)   // shift immediates carry funct7
            return enc_i({f7, r[24:20]}, r[12:8], r[2:0], r[7:3], rv_pkg::op_imm);
        return enc_i(r[31:20], r[12:8], r[2:0], r[7:3], rv_pkg::op_imm);
    endfunction

    function automatic rv_pkg::word_t alu_ref(logic [2:0] f3, logic alt, rv_pkg::word_t x,
                                              rv_pkg::word_t y);
        case (f3)
            3'd0: return alt ? x - y : x + y;
            3'd1: return x << y[4:0];
            3'd2: return ($signed(x) < $signed(y)) ? 32'd1 : 32'd0;
            3'd3: return (x < y) ? 32'd1 : 32'd0;
            3'd4: return x ^ y;
            3'd5: return alt ? $unsigned($signed(x) >>> y[4:0]) : x >> y[4:0];
            3'd6: return x | y;
            default: return x & y;
        endcase
    endfunction

    // executes one instruction on the model, returns the expected record
    function automatic rec_t ref_exec(input rv_pkg::word_t w);
        rec_t r;
        rv_pkg::word_t a, b, ii, is, ib, ij, addr;
        logic [2:0] f3;
        logic take;
        a  = m_regs[w[19:15]];
        b  = m_regs[w[24:20]];
        f3 = w[14:12];
        ii = {{20{w[31]}}, w[31:20]};
        is = {{20{w[31]}}, w[31:25], w[11:7]};
        ib = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        ij = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        take = 1'b0;
        r.pc = m_pc;
        r.rd = w[11:7];
        r.we = 1'b0;
        r.data = '0;
        r.next_pc = m_pc + 4;
        case (w[6:0])
            rv_pkg::op_reg: begin
                r.we = 1'b1;
                r.data = alu_ref(f3, w[30], a, b);
            end
            rv_pkg::op_imm: begin
                r.we = 1'b1;
                r.data = alu_ref(f3, (f3 == 3'd5) && w[30], a, ii);   // no subi
            end
            rv_pkg::op_load: begin
                addr = a + ii;
                r.we = 1'b1;
                r.data = m_mem[addr[7:2]];
            end
            rv_pkg::op_store: begin
                addr = a + is;
                m_mem[addr[7:2]] = b;
            end
            rv_pkg::op_branch: begin
                case (f3)
                    3'd0: take = (a == b);
                    3'd1: take = (a != b);
                    3'd4: take = ($signed(a) < $signed(b));
                    3'd5: take = ($signed(a) >= $signed(b));
                    3'd6: take = (a < b);
                    3'd7: take = (a >= b);
                    default: take = 1'b0;
                endcase
                if (take) r.next_pc = m_pc + ib;
            end
            rv_pkg::op_jal: begin
                r.we = 1'b1;
                r.data = m_pc + 4;
                r.next_pc = m_pc + ij;
            end
            rv_pkg::op_jalr: begin
                r.we = 1'b1;
                r.data = m_pc + 4;
                r.next_pc = (a + ii) & ~32'd1;
            end
            rv_pkg::op_lui: begin
                r.we = 1'b1;
                r.data = {w[31:12], 12'b0};
            end
            default: ;
        endcase
        if (r.we && r.rd != 5'd0) m_regs[r.rd] = r.data;
        m_pc = r.next_pc;
        return r;
    endfunction

    task automatic check_value(string what, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    task automatic build_program();
        int f3s [6] = '{0, 1, 4, 5, 6, 7};
        int t1 [6] = '{2, 1, 1, 2, 2, 1};   // operands making each branch taken
        int t2 [6] = '{2, 2, 2, 1, 1, 2};
        int n1 [6] = '{1, 2, 2, 1, 1, 2};   // and not taken
        int n2 [6] = '{2, 2, 1, 2, 2, 1};
        prog.push_back(enc_i(-12'sd5, 0, 3'd0, 1, rv_pkg::op_imm));
        prog.push_back(enc_i(12'd3, 0, 3'd0, 2, rv_pkg::op_imm));
        prog.push_back(enc_r(7'h00, 2, 1, 3'd0, 3));
        prog.push_back(enc_r(7'h20, 1, 2, 3'd0, 4));     // sub
        prog.push_back(enc_r(7'h20, 2, 1, 3'd5, 5));     // sra
        prog.push_back(enc_r(7'h00, 2, 1, 3'd5, 6));     // srl
        prog.push_back(enc_r(7'h00, 2, 1, 3'd2, 7));
        prog.push_back(enc_r(7'h00, 2, 1, 3'd3, 8));
        prog.push_back(enc_i(12'h7ff, 1, 3'd4, 9, rv_pkg::op_imm));
        prog.push_back(enc_i(12'hfff, 1, 3'd2, 10, rv_pkg::op_imm));
        prog.push_back(enc_i(12'hfff, 2, 3'd3, 11, rv_pkg::op_imm));
        prog.push_back(enc_i(12'h401, 1, 3'd5, 12, rv_pkg::op_imm));
        prog.push_back({20'habcde, 5'd14, rv_pkg::op_lui});
        prog.push_back(enc_s(12'd13, 14, 2));
        prog.push_back(enc_i(12'd13, 2, 3'd2, 15, rv_pkg::op_load));
        prog.push_back(enc_i(12'd77, 0, 3'd0, 0, rv_pkg::op_imm));   // write to x0
        prog.push_back(enc_r(7'h00, 2, 0, 3'd0, 16));
        for (int k = 0; k < 6; k++) begin
            prog.push_back(enc_b(13'd8, t1[k], t2[k], f3s[k]));
            prog.push_back(enc_i(12'd1, 20, 3'd0, 20, rv_pkg::op_imm));
            prog.push_back(enc_b(13'd8, n1[k], n2[k], f3s[k]));
            prog.push_back(enc_i(12'd1, 20, 3'd0, 20, rv_pkg::op_imm));
        end
        prog.push_back(enc_j(21'd8, 21));
        prog.push_back(enc_i(12'd1, 20, 3'd0, 20, rv_pkg::op_imm));
        prog.push_back(enc_i(12'd181, 0, 3'd0, 22, rv_pkg::op_imm));
        prog.push_back(enc_i(12'd4, 22, 3'd0, 23, rv_pkg::op_jalr));  // odd target
        prog.push_back(enc_i(12'd1, 20, 3'd0, 20, rv_pkg::op_imm));
        prog.push_back(enc_i(12'd13, 2, 3'd2, 24, rv_pkg::op_load));
    endtask

    always @(posedge clk) begin
        res_ready <= ($random(ready_seed) & 3) != 0;
    end

    // compares every cycle a record is shown, so stalled values are checked too
    always @(posedge clk) begin
        if (!reset && res_valid) begin
            if (exp_q.size() == 0) begin
                $display("DUT produced a record that was never expected at %0t", $time);
                errors++;
            end else begin
                check_value("pc", res_pc, exp_q[0].pc);
                check_value("rd", 32'(res_rd), 32'(exp_q[0].rd));
                check_value("we", 32'(res_we), 32'(exp_q[0].we));
                check_value("next_pc", res_next_pc, exp_q[0].next_pc);
                if (exp_q[0].we) check_value("data", res_data, exp_q[0].data);
                if (res_ready) void'(exp_q.pop_front());
            end
        end
    end

    // occupancy of the record stage, followed from the handshakes
    always @(posedge clk) begin
        if (reset) begin
            held <= 1'b0;
        end else begin
            check_value("res_valid", 32'(res_valid), 32'(held));
            check_value("instr_ready", 32'(instr_ready), 32'(!held || res_ready));
            if (instr_valid && instr_ready) begin
                held <= 1'b1;
            end else if (res_ready) begin
                held <= 1'b0;
            end
        end
    end

    initial begin
        rv_pkg::word_t w;
        int rand_left;
        int t;
        ready_seed = seed + 1;
        reset = 1'b1;
        instr_valid = 1'b0;
        instr = '0;
        res_ready = 1'b0;
        m_pc = '0;
        rand_left = 40;
        for (int i = 0; i < 32; i++) m_regs[i] = '0;
        for (int i = 0; i < 64; i++) m_mem[i] = '0;
        build_program();
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        while (rand_left > 0 && timeouts == 0) begin
            if ((m_pc >> 2) < prog.size()) begin
                w = prog[m_pc >> 2];             // follow the reported control flow
            end else begin
                w = random_alu();
                rand_left--;
            end
            exp_q.push_back(ref_exec(w));
            instr_valid <= 1'b1;
            instr <= w;
            t = 0;
            do begin
                @(posedge clk);
                t++;
            end while (!instr_ready && t < wait_limit);
            if (!instr_ready) begin
                $display("timed out waiting for the core to accept an instruction");
                timeouts++;
            end
        end
        instr_valid <= 1'b0;
        t = 0;
        while (exp_q.size() != 0 && t < wait_limit) begin
            @(posedge clk);
            t++;
        end
        if (exp_q.size() != 0) begin
            $display("timed out with %0d records never retired", exp_q.size());
            timeouts++;
        end
        $display("errors: %0d  timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// ==== rv_core.f ====
rv_pkg.sv
rv_controller.sv
rv_imm_gen.sv
rv_regfile.sv
rv_alu.sv
rv_data_mem.sv
rv_result_select.sv
rv_core.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     ?= --timing -j 0
TOP       ?= tb_rv_core
FILELIST  ?= rv_core.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
